//--- Bender.yml
package:
  name: ex_block

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ex_op_pkg.sv
      - hw/ex_bus_pkg.sv
      - hw/ex_issue.sv
      - hw/ex_alu.sv
      - hw/ex_multdiv.sv
      - hw/ex_result.sv
      - hw/ex_block.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/ex_block_assert.sv
      - bench/ex_block_tb.sv

//--- bench/ex_block_assert.sv
/*
 * Protocol assertions on the issue strobe and the valid level.
 * Bound to ex_block from the testbench; violations holds the failure count.
 */

module ex_block_assert (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 issue_i,
  input ex_bus_pkg::ex_req_t  req_i,
  input logic                 valid_o,
  input logic                 busy_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned violations = 0;

  // No issue while the mul/div unit works
  issue_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_i |-> !busy_o)
    else begin
      $error("issue_i asserted while busy_o is high");
      violations++;
    end

  // ALU result in the cycle after issue, high for exactly one cycle
  alu_valid_next: assert property (@(posedge clk_i) disable iff (rst_i)
    (issue_i && !busy_o && !req_i.is_md) ##1 !issue_i |-> valid_o ##1 !valid_o)
    else begin
      $error("valid_o not high for exactly one cycle after an ALU issue");
      violations++;
    end

  reset_quiet: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !valid_o ##1 !valid_o)
    else begin
      $error("valid_o high within two cycles after reset");
      violations++;
    end

endmodule

//--- bench/ex_block_tb.sv
/*
 * Directed testbench for the execution stage.
 * Issues ALU and mul/div requests, compares the responses with a behavioral
 * model and exercises back-pressure and reset in the middle of an operation.
 */

`include "ex_config.svh"

module ex_block_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int XW         = `EX_XLEN;
  localparam int CLK_PERIOD = 4;
  localparam int MD_WAIT    = `EX_MD_ITER + 4;
  // Operations issued over all tests
  localparam int NUM_OPS    = 1060;

  logic                 clk_i;
  logic                 rst_i;
  logic                 issue_i;
  ex_bus_pkg::ex_req_t  req_i;
  logic                 ready_i;
  ex_bus_pkg::ex_rsp_t  rsp_o;
  logic                 valid_o;
  logic                 busy_o;

  integer               seed;
  logic [XW-1:0]        edge_vals [6];

  ex_block dut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .issue_i (issue_i),
    .req_i   (req_i),
    .ready_i (ready_i),
    .rsp_o   (rsp_o),
    .valid_o (valid_o),
    .busy_o  (busy_o)
  );

  bind ex_block ex_block_assert u_assert (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .issue_i (issue_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .busy_o  (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(100 * NUM_OPS * MD_WAIT * CLK_PERIOD);
    stop_on_failure("Timeout: the tests did not finish within the watchdog limit");
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // RISC-V branch rules, SLT and SLTU follow LT and LTU
  function automatic logic expected_branch(ex_op_pkg::alu_op_e op, logic [XW-1:0] a,
                                           logic [XW-1:0] b);
    case (op)
      ex_op_pkg::EQ:                  return a == b;
      ex_op_pkg::NE:                  return a != b;
      ex_op_pkg::SLT, ex_op_pkg::LT:  return $signed(a) < $signed(b);
      ex_op_pkg::GE:                  return $signed(a) >= $signed(b);
      ex_op_pkg::SLTU, ex_op_pkg::LTU: return a < b;
      ex_op_pkg::GEU:                 return a >= b;
      default:                        return 1'b0;
    endcase
  endfunction

  function automatic logic [XW-1:0] expected_alu(ex_op_pkg::alu_op_e op, logic [XW-1:0] a,
                                                 logic [XW-1:0] b);
    logic [$clog2(XW)-1:0] sh;
    sh = b[$clog2(XW)-1:0];
    case (op)
      ex_op_pkg::ADD: return a + b;
      ex_op_pkg::SUB: return a - b;
      ex_op_pkg::AND: return a & b;
      ex_op_pkg::OR:  return a | b;
      ex_op_pkg::XOR: return a ^ b;
      ex_op_pkg::SLL: return a << sh;
      ex_op_pkg::SRL: return a >> sh;
      ex_op_pkg::SRA: return $signed(a) >>> sh;
      default:        return {{(XW-1){1'b0}}, expected_branch(op, a, b)};
    endcase
  endfunction

  function automatic logic [XW-1:0] expected_md(ex_op_pkg::md_op_e op, logic [XW-1:0] a,
                                                logic [XW-1:0] b);
    logic signed [2*XW-1:0] ss;
    logic signed [2*XW-1:0] su;
    logic [2*XW-1:0]        uu;
    logic signed [XW-1:0]   sa;
    logic signed [XW-1:0]   sb;
    logic [XW-1:0]          min_int;
    logic                   ovf;
    logic [XW-1:0]          sq;
    logic [XW-1:0]          sr;
    sa      = a;
    sb      = b;
    ss      = sa * sb;
    su      = sa * $signed({1'b0, b});
    uu      = {{XW{1'b0}}, a} * {{XW{1'b0}}, b};
    min_int = {1'b1, {(XW-1){1'b0}}};
    ovf     = (a == min_int) && (b == '1);
    // Signed quotient and remainder, with the RISC-V corner cases
    if (b == '0) begin
      sq = '1;
      sr = a;
    end else if (ovf) begin
      sq = min_int;
      sr = '0;
    end else begin
      sq = sa / sb;
      sr = sa % sb;
    end
    case (op)
      ex_op_pkg::MUL:    return ss[XW-1:0];
      ex_op_pkg::MULH:   return ss[2*XW-1:XW];
      ex_op_pkg::MULHSU: return su[2*XW-1:XW];
      ex_op_pkg::MULHU:  return uu[2*XW-1:XW];
      ex_op_pkg::DIV:    return sq;
      ex_op_pkg::DIVU:   return (b == '0) ? '1 : a / b;
      ex_op_pkg::REM:    return sr;
      default:           return (b == '0) ? a : a % b;
    endcase
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input logic [XW-1:0] got,
                            input logic [XW-1:0] exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp));
    end
  endtask

  task automatic check_rsp(input ex_bus_pkg::ex_rsp_t got, input ex_bus_pkg::ex_rsp_t exp);
    check_word("rsp_o.result", got.result, exp.result);
    check_word("rsp_o.adder_result", got.adder_result, exp.adder_result);
    check_word("rsp_o.branch_target", got.branch_target, exp.branch_target);
    check_bit("rsp_o.branch_decision", got.branch_decision, exp.branch_decision);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  function automatic ex_bus_pkg::ex_req_t make_req(logic is_md, ex_op_pkg::alu_op_e aop,
                                                   ex_op_pkg::md_op_e mop,
                                                   logic [XW-1:0] a, logic [XW-1:0] b);
    ex_bus_pkg::ex_req_t req;
    req.is_md     = is_md;
    req.alu_op    = aop;
    req.md_op     = mop;
    req.operand_a = a;
    req.operand_b = b;
    req.bt_a      = $random(seed);
    req.bt_b      = $random(seed);
    return req;
  endfunction

  // Starts and ends on a falling edge
  task automatic send_req(input ex_bus_pkg::ex_req_t req);
    issue_i = 1'b1;
    req_i   = req;
    @(negedge clk_i);
    issue_i = 1'b0;
  endtask

  // Bounded wait on the falling edge for a mul/div result
  task automatic wait_for_valid();
    int waited;
    waited = 0;
    while (!valid_o) begin
      if (waited == MD_WAIT) begin
        stop_on_failure("Timeout: valid_o never rose after a mul/div issue");
      end
      @(negedge clk_i);
      waited++;
    end
  endtask

  task automatic run_alu(input ex_op_pkg::alu_op_e op, input logic [XW-1:0] a,
                         input logic [XW-1:0] b);
    ex_bus_pkg::ex_req_t req;
    ex_bus_pkg::ex_rsp_t exp;
    req                 = make_req(1'b0, op, ex_op_pkg::MUL, a, b);
    exp.result          = expected_alu(op, a, b);
    exp.branch_target   = req.bt_a + req.bt_b;
    exp.branch_decision = expected_branch(op, a, b);
    // Shared adder subtracts for SUB and the ordering compares
    if (op inside {ex_op_pkg::SUB, ex_op_pkg::SLT, ex_op_pkg::SLTU, ex_op_pkg::LT,
                   ex_op_pkg::GE, ex_op_pkg::LTU, ex_op_pkg::GEU}) begin
      exp.adder_result = a - b;
    end else begin
      exp.adder_result = a + b;
    end
    send_req(req);
    check_bit("valid_o", valid_o, 1'b1);
    check_rsp(rsp_o, exp);
    @(negedge clk_i);
    check_bit("valid_o", valid_o, 1'b0);
  endtask

  // Holds ready_i low for stall cycles once the result is valid
  task automatic run_md(input ex_op_pkg::md_op_e op, input logic [XW-1:0] a,
                        input logic [XW-1:0] b, input int stall);
    ex_bus_pkg::ex_req_t req;
    logic [XW-1:0]       exp;
    int                  cycle;
    req     = make_req(1'b1, ex_op_pkg::ADD, op, a, b);
    exp     = expected_md(op, a, b);
    ready_i = (stall == 0);
    send_req(req);
    check_bit("busy_o", busy_o, 1'b1);
    wait_for_valid();
    check_word("rsp_o.result", rsp_o.result, exp);
    for (cycle = 0; cycle < stall; cycle++) begin
      @(negedge clk_i);
      check_bit("valid_o", valid_o, 1'b1);
      check_bit("busy_o", busy_o, 1'b1);
      check_word("rsp_o.result", rsp_o.result, exp);
    end
    ready_i = 1'b1;
    @(negedge clk_i);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
  endtask

  task automatic alu_sweep();
    int k;
    int i;
    int j;
    for (k = 0; k < 16; k++) begin
      for (i = 0; i < 6; i++) begin
        for (j = 0; j < 6; j++) begin
          run_alu(ex_op_pkg::alu_op_e'(k), edge_vals[i], edge_vals[j]);
        end
      end
      for (i = 0; i < 8; i++) begin
        run_alu(ex_op_pkg::alu_op_e'(k), $random(seed), $random(seed));
      end
    end
  endtask

  // Edge pairs cover division by zero and the signed overflow case
  task automatic md_sweep();
    int k;
    int i;
    int j;
    for (k = 0; k < 8; k++) begin
      for (i = 0; i < 6; i++) begin
        for (j = 0; j < 6; j++) begin
          run_md(ex_op_pkg::md_op_e'(k), edge_vals[i], edge_vals[j], 0);
        end
      end
      for (i = 0; i < 8; i++) begin
        run_md(ex_op_pkg::md_op_e'(k), $random(seed), $random(seed), 0);
      end
    end
  endtask

  // Reset while a divide result waits for decode
  task automatic reset_mid_op();
    ready_i = 1'b0;
    send_req(make_req(1'b1, ex_op_pkg::ADD, ex_op_pkg::DIV, $random(seed), $random(seed)));
    wait_for_valid();
    check_bit("busy_o", busy_o, 1'b1);
    rst_i = 1'b1;
    @(negedge clk_i);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    rst_i   = 1'b0;
    ready_i = 1'b1;
    repeat (2) @(negedge clk_i);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
  endtask

  initial begin
    seed      = 32'h9f74;
    rst_i     = 1'b1;
    issue_i   = 1'b0;
    req_i     = '0;
    ready_i   = 1'b1;
    edge_vals = '{32'h0000_0000, 32'h0000_0001, 32'h0000_0010,
                  32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);

    alu_sweep();
    md_sweep();
    // Back-pressure, then a normal issue right after
    run_md(ex_op_pkg::MULH, $random(seed), $random(seed), 6);
    run_md(ex_op_pkg::DIVU, $random(seed), $random(seed), 0);
    reset_mid_op();
    run_alu(ex_op_pkg::ADD, $random(seed), $random(seed));

    if (dut.u_assert.violations != 0) begin
      stop_on_failure("Protocol assertions failed during the run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- hw/ex_alu.sv
/*
 * Single-cycle integer ALU.
 * One shared adder covers ADD, SUB and all magnitude compares; a separate
 * adder forms the branch target. Purely combinational.
 */

`include "ex_config.svh"

module ex_alu (
  input  ex_bus_pkg::ex_req_t  req_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic [`EX_XLEN-1:0]  adder_result_o,
  output logic [`EX_XLEN-1:0]  branch_target_o,
  output logic                 cmp_result_o
);

  localparam int XW  = `EX_XLEN;
  localparam int SHW = $clog2(`EX_XLEN);

  logic [XW-1:0]  op_a;
  logic [XW-1:0]  op_b;
  logic           negate;
  logic           is_signed;
  logic [XW:0]    a_ext;
  logic [XW:0]    b_ext;
  logic [XW:0]    sum_ext;
  logic           is_equal;
  logic           is_less;
  logic [SHW-1:0] shamt;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  assign shamt = op_b[SHW-1:0];

  ////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////

  // Subtract for SUB and every ordering compare
  assign negate = req_i.alu_op inside {ex_op_pkg::SUB, ex_op_pkg::SLT, ex_op_pkg::SLTU,
                                       ex_op_pkg::LT, ex_op_pkg::GE, ex_op_pkg::LTU,
                                       ex_op_pkg::GEU};

  assign is_signed = req_i.alu_op inside {ex_op_pkg::SLT, ex_op_pkg::LT, ex_op_pkg::GE};

  // One extra bit so the top bit of a-b is the less-than flag
  assign a_ext   = {is_signed & op_a[XW-1], op_a};
  assign b_ext   = {is_signed & op_b[XW-1], op_b};
  assign sum_ext = a_ext + (negate ? ~b_ext : b_ext) + {{XW{1'b0}}, negate};

  assign adder_result_o = sum_ext[XW-1:0];
  assign is_less        = sum_ext[XW];
  assign is_equal       = (op_a == op_b);

  // Branch decision, also feeds SLT/SLTU
  always_comb begin
    case (req_i.alu_op)
      ex_op_pkg::EQ:                  cmp_result_o = is_equal;
      ex_op_pkg::NE:                  cmp_result_o = ~is_equal;
      ex_op_pkg::SLT, ex_op_pkg::LT,
      ex_op_pkg::SLTU, ex_op_pkg::LTU: cmp_result_o = is_less;
      ex_op_pkg::GE, ex_op_pkg::GEU:  cmp_result_o = ~is_less;
      default:                        cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    case (req_i.alu_op)
      ex_op_pkg::ADD, ex_op_pkg::SUB: result_o = sum_ext[XW-1:0];
      ex_op_pkg::AND:                 result_o = op_a & op_b;
      ex_op_pkg::OR:                  result_o = op_a | op_b;
      ex_op_pkg::XOR:                 result_o = op_a ^ op_b;
      ex_op_pkg::SLL:                 result_o = op_a << shamt;
      ex_op_pkg::SRL:                 result_o = op_a >> shamt;
      ex_op_pkg::SRA:                 result_o = $unsigned($signed(op_a) >>> shamt);
      default:                        result_o = {{(XW-1){1'b0}}, cmp_result_o};
    endcase
  end

  // Dedicated branch target adder, carry out dropped
  assign branch_target_o = req_i.bt_a + req_i.bt_b;

endmodule

//--- hw/ex_block.sv
/*
 * Top of the execution stage: issue register, ALU, mul/div unit and result.
 * Issue only while busy_o is low; results are marked by valid_o.
 */

`include "ex_config.svh"

module ex_block (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 issue_i,
  input  ex_bus_pkg::ex_req_t  req_i,
  input  logic                 ready_i,
  output ex_bus_pkg::ex_rsp_t  rsp_o,
  output logic                 valid_o,
  output logic                 busy_o
);

  ex_bus_pkg::ex_req_t  issued_req;
  logic                 alu_go;
  logic                 md_start;
  logic [`EX_XLEN-1:0]  alu_result;
  logic [`EX_XLEN-1:0]  adder_result;
  logic [`EX_XLEN-1:0]  branch_target;
  logic                 cmp_result;
  logic [`EX_XLEN-1:0]  md_result;
  logic                 md_done;

  ex_issue u_issue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .issue_i      (issue_i),
    .req_i        (req_i),
    .busy_i       (busy_o),
    .issued_req_o (issued_req),
    .alu_go_o     (alu_go),
    .md_start_o   (md_start)
  );

  ex_alu u_alu (
    .req_i           (issued_req),
    .result_o        (alu_result),
    .adder_result_o  (adder_result),
    .branch_target_o (branch_target),
    .cmp_result_o    (cmp_result)
  );

  ex_multdiv u_multdiv (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (md_start),
    .op_i     (issued_req.md_op),
    .op_a_i   (issued_req.operand_a),
    .op_b_i   (issued_req.operand_b),
    .ready_i  (ready_i),
    .result_o (md_result),
    .done_o   (md_done),
    .busy_o   (busy_o)
  );

  ex_result u_result (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .alu_go_i        (alu_go),
    .alu_result_i    (alu_result),
    .adder_result_i  (adder_result),
    .branch_target_i (branch_target),
    .cmp_result_i    (cmp_result),
    .md_done_i       (md_done),
    .md_result_i     (md_result),
    .rsp_o           (rsp_o),
    .valid_o         (valid_o)
  );

endmodule

//--- hw/ex_bus_pkg.sv
/*
 * Request and response bundles passed into and out of the execution stage.
 * Widths follow the config header.
 */

`include "ex_config.svh"

package ex_bus_pkg;

  // One issued operation, 136 bits
  typedef struct packed {
    // Selects the mul/div unit instead of the ALU
    logic                  is_md;
    ex_op_pkg::alu_op_e    alu_op;
    ex_op_pkg::md_op_e     md_op;
    logic [`EX_XLEN-1:0]   operand_a;
    logic [`EX_XLEN-1:0]   operand_b;
    // Branch target operands, usually PC and immediate
    logic [`EX_XLEN-1:0]   bt_a;
    logic [`EX_XLEN-1:0]   bt_b;
  } ex_req_t;

  // Result bundle back to decode, fetch and LSU, 97 bits
  typedef struct packed {
    logic [`EX_XLEN-1:0]   result;
    // Raw adder output, used by the LSU for addresses
    logic [`EX_XLEN-1:0]   adder_result;
    logic [`EX_XLEN-1:0]   branch_target;
    logic                  branch_decision;
  } ex_rsp_t;

endpackage

//--- hw/ex_config.svh
/*
 * Global sizing for the execution stage.
 * Include wherever the data width or the mul/div iteration count is needed.
 */

`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Integer register width
`define EX_XLEN 32

// One iteration per operand bit for the iterative mul/div
`define EX_MD_ITER 32

`endif

//--- hw/ex_issue.sv
/*
 * Issue register of the execution stage.
 * Captures an accepted request and fires a one-cycle go strobe to the ALU
 * or a start strobe to the mul/div unit.
 */

module ex_issue (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 issue_i,
  input  ex_bus_pkg::ex_req_t  req_i,
  input  logic                 busy_i,
  output ex_bus_pkg::ex_req_t  issued_req_o,
  output logic                 alu_go_o,
  output logic                 md_start_o
);

  logic                 accept;
  ex_bus_pkg::ex_req_t  req_q;
  logic                 alu_go_q;
  logic                 md_start_q;

  // Strobes during a mul/div run are dropped
  assign accept = issue_i & ~busy_i;

  ////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      alu_go_q   <= 1'b0;
      md_start_q <= 1'b0;
    end else begin
      alu_go_q   <= accept & ~req_i.is_md;
      md_start_q <= accept & req_i.is_md;
    end
  end

  // Request payload, held until the next accepted issue
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign issued_req_o = req_q;
  assign alu_go_o     = alu_go_q;
  assign md_start_o   = md_start_q;

endmodule

//--- hw/ex_multdiv.sv
/*
 * Iterative RV32M unit: shift-add multiply and restoring divide on operand
 * magnitudes, one bit per cycle, with sign fix-up on the way out.
 * The result is held in DONE until decode raises ready_i.
 */

`include "ex_config.svh"

module ex_multdiv (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  ex_op_pkg::md_op_e    op_i,
  input  logic [`EX_XLEN-1:0]  op_a_i,
  input  logic [`EX_XLEN-1:0]  op_b_i,
  input  logic                 ready_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 done_o,
  output logic                 busy_o
);

  localparam int                XW       = `EX_XLEN;
  localparam int                CNT_W    = $clog2(`EX_MD_ITER);
  localparam logic [CNT_W-1:0]  CNT_LAST = CNT_W'(`EX_MD_ITER - 1);

  ex_op_pkg::md_state_e  state_q;
  ex_op_pkg::md_state_e  state_d;
  logic [CNT_W-1:0]      cnt_q;

  // Operation context, captured at start
  ex_op_pkg::md_op_e     op_q;
  logic                  neg_a_q;
  logic                  neg_b_q;
  logic                  div_zero_q;
  // Multiplicand or divisor magnitude
  logic [XW-1:0]         opnd_q;
  // {high, low}: partial product or {remainder, quotient}
  logic [2*XW-1:0]       acc_q;

  logic                  start_div;
  logic                  is_div;
  logic                  a_signed;
  logic                  b_signed;
  logic                  neg_a;
  logic                  neg_b;
  logic [XW-1:0]         mag_a;
  logic [XW-1:0]         mag_b;
  logic [XW:0]           mul_sum;
  logic [XW:0]           rem_sh;
  logic [XW:0]           div_diff;
  logic [2*XW-1:0]       acc_step;
  logic [2*XW-1:0]       prod_fix;
  logic [XW-1:0]         quo_fix;
  logic [XW-1:0]         rem_fix;

  ////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////

  assign a_signed  = op_i inside {ex_op_pkg::MULH, ex_op_pkg::MULHSU,
                                  ex_op_pkg::DIV, ex_op_pkg::REM};
  assign b_signed  = op_i inside {ex_op_pkg::MULH, ex_op_pkg::DIV, ex_op_pkg::REM};
  assign start_div = op_i inside {ex_op_pkg::DIV, ex_op_pkg::DIVU,
                                  ex_op_pkg::REM, ex_op_pkg::REMU};

  assign neg_a = a_signed & op_a_i[XW-1];
  assign neg_b = b_signed & op_b_i[XW-1];
  assign mag_a = neg_a ? -op_a_i : op_a_i;
  assign mag_b = neg_b ? -op_b_i : op_b_i;

  ////////////////////////////////////////
  // Iteration step
  ////////////////////////////////////////

  assign is_div = op_q inside {ex_op_pkg::DIV, ex_op_pkg::DIVU,
                               ex_op_pkg::REM, ex_op_pkg::REMU};

  // Multiply: add multiplicand if LSB set, then shift right
  assign mul_sum = {1'b0, acc_q[2*XW-1:XW]} + (acc_q[0] ? {1'b0, opnd_q} : '0);

  // Divide: shift left, trial subtract, keep if non-negative
  assign rem_sh   = acc_q[2*XW-1:XW-1];
  assign div_diff = rem_sh - {1'b0, opnd_q};

  always_comb begin
    if (!is_div) begin
      acc_step = {mul_sum, acc_q[XW-1:1]};
    end else if (!div_diff[XW]) begin
      acc_step = {div_diff[XW-1:0], acc_q[XW-2:0], 1'b1};
    end else begin
      acc_step = {rem_sh[XW-1:0], acc_q[XW-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_op_pkg::IDLE: if (start_i)           state_d = ex_op_pkg::CALC;
      ex_op_pkg::CALC: if (cnt_q == CNT_LAST) state_d = ex_op_pkg::DONE;
      ex_op_pkg::DONE: if (ready_i)           state_d = ex_op_pkg::IDLE;
      default:                                state_d = ex_op_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ex_op_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= (state_q == ex_op_pkg::CALC) ? cnt_q + 1'b1 : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ex_op_pkg::IDLE && start_i) begin
      op_q       <= op_i;
      neg_a_q    <= neg_a;
      neg_b_q    <= neg_b;
      div_zero_q <= (op_b_i == '0);
      opnd_q     <= start_div ? mag_b : mag_a;
      acc_q      <= {{XW{1'b0}}, start_div ? mag_a : mag_b};
    end else if (state_q == ex_op_pkg::CALC) begin
      acc_q <= acc_step;
    end
  end

  ////////////////////////////////////////
  // Sign fix-up and result
  ////////////////////////////////////////

  assign prod_fix = (neg_a_q ^ neg_b_q) ? -acc_q : acc_q;
  assign quo_fix  = (neg_a_q ^ neg_b_q) ? -acc_q[XW-1:0] : acc_q[XW-1:0];
  // Remainder takes the sign of the dividend
  assign rem_fix  = neg_a_q ? -acc_q[2*XW-1:XW] : acc_q[2*XW-1:XW];

  // Most negative / -1 needs no special case, the negated quotient wraps to it
  // and the remainder comes out zero
  always_comb begin
    case (op_q)
      ex_op_pkg::MUL:                     result_o = prod_fix[XW-1:0];
      ex_op_pkg::MULH, ex_op_pkg::MULHSU,
      ex_op_pkg::MULHU:                   result_o = prod_fix[2*XW-1:XW];
      ex_op_pkg::DIV, ex_op_pkg::DIVU:    result_o = div_zero_q ? '1 : quo_fix;
      default:                            result_o = rem_fix;
    endcase
  end

  assign done_o = (state_q == ex_op_pkg::DONE);
  // Start strobe counts as busy so a same-cycle issue is refused
  assign busy_o = start_i | (state_q != ex_op_pkg::IDLE);

endmodule

//--- hw/ex_op_pkg.sv
/*
 * Operator and state encodings for the execution stage.
 * Referenced by scoped name from the ALU, the mul/div unit and the request bus.
 */

package ex_op_pkg;

  // ALU operators, arithmetic and logic first, then branch comparisons
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // RV32M operators in funct3 order
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } md_op_e;

  // Mul/div controller
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } md_state_e;

endpackage

//--- hw/ex_result.sv
/*
 * Output side of the execution stage.
 * Builds the response bundle and freezes it while a mul/div result waits
 * for decode to take it.
 */

`include "ex_config.svh"

module ex_result (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 alu_go_i,
  input  logic [`EX_XLEN-1:0]  alu_result_i,
  input  logic [`EX_XLEN-1:0]  adder_result_i,
  input  logic [`EX_XLEN-1:0]  branch_target_i,
  input  logic                 cmp_result_i,
  input  logic                 md_done_i,
  input  logic [`EX_XLEN-1:0]  md_result_i,
  output ex_bus_pkg::ex_rsp_t  rsp_o,
  output logic                 valid_o
);

  ex_bus_pkg::ex_rsp_t  rsp_d;
  ex_bus_pkg::ex_rsp_t  rsp_q;
  logic                 hold_q;

  always_comb begin
    rsp_d.result          = md_done_i ? md_result_i : alu_result_i;
    rsp_d.adder_result    = adder_result_i;
    rsp_d.branch_target   = branch_target_i;
    rsp_d.branch_decision = cmp_result_i;
  end

  // Set from the second cycle of a waiting mul/div result
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= md_done_i;
    end
  end

  // Snapshot on the first done cycle
  always_ff @(posedge clk_i) begin
    if (md_done_i && !hold_q) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o   = hold_q ? rsp_q : rsp_d;
  assign valid_o = alu_go_i | md_done_i;

endmodule

//--- project.f
+incdir+hw
hw/ex_op_pkg.sv
hw/ex_bus_pkg.sv
hw/ex_issue.sv
hw/ex_alu.sv
hw/ex_multdiv.sv
hw/ex_result.sv
hw/ex_block.sv
bench/ex_block_assert.sv
bench/ex_block_tb.sv
